//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q '^STATUS: PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/axil_master.sv
`timescale 1ns/1ps
`default_nettype none

module axil_master (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               empty,
    output logic                    pop,
    input  wire mem_pkg::mem_req_t  pop_data,
    output logic                    awvalid,
    input  wire logic               awready,
    output logic [31:0]             awaddr,
    output logic                    wvalid,
    input  wire logic               wready,
    output logic [63:0]             wdata,
    output logic [7:0]              wstrb,
    input  wire logic               bvalid,
    output logic                    bready,
    input  wire logic [1:0]         bresp,
    output logic                    arvalid,
    input  wire logic               arready,
    output logic [31:0]             araddr,
    input  wire logic               rvalid,
    output logic                    rready,
    input  wire logic [63:0]        rdata,
    input  wire logic [1:0]         rresp,
    output logic                    rsp_valid,
    input  wire logic               rsp_ready,
    output mem_pkg::mem_rsp_t       rsp
);
    import mem_pkg::*;

    typedef enum logic [1:0] {IDLE, WRITE, READ, RESP} state_e;

    state_e      state;
    mem_req_t    req;
    logic        aw_done;
    logic        w_done;
    logic        ar_done;
    logic [63:0] lane_data;
    logic [63:0] load_ext;

    assign pop       = (state == IDLE) && !empty;
    assign rsp_valid = (state == RESP);

    // bus address is the doubleword holding the access
    assign awaddr  = {req.addr[31:3], 3'b000};
    assign araddr  = {req.addr[31:3], 3'b000};
    assign wdata   = req.wdata;
    assign wstrb   = req.wstrb;
    assign awvalid = (state == WRITE) && !aw_done;
    assign wvalid  = (state == WRITE) && !w_done;
    assign bready  = (state == WRITE);
    assign arvalid = (state == READ) && !ar_done;
    assign rready  = (state == READ);

    // pick the field out of its lane, then extend
    always_comb begin
        lane_data = rdata >> {req.addr[2:0], 3'b000};
        load_ext  = rdata;
        case (req.width)
            WDT8:  load_ext = {{56{!req.is_unsigned && lane_data[7]}}, lane_data[7:0]};
            WDT16: load_ext = {{48{!req.is_unsigned && lane_data[15]}}, lane_data[15:0]};
            WDT32: load_ext = {{32{!req.is_unsigned && lane_data[31]}}, lane_data[31:0]};
            WDT64: load_ext = rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            ar_done <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (!empty) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        ar_done <= 1'b0;
                        if (pop_data.misaligned) begin
                            state <= RESP;
                        end else if (pop_data.op == OP_STORE) begin
                            state <= WRITE;
                        end else begin
                            state <= READ;
                        end
                    end
                end
                WRITE: begin
                    if (awvalid && awready) begin
                        aw_done <= 1'b1;
                    end
                    if (wvalid && wready) begin
                        w_done <= 1'b1;
                    end
                    if (bvalid) begin
                        state <= RESP;
                    end
                end
                READ: begin
                    if (arvalid && arready) begin
                        ar_done <= 1'b1;
                    end
                    if (rvalid) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (rsp_ready) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // misaligned requests leave here with error set and data zero
    always_ff @(posedge clk) begin
        if (pop) begin
            req       <= pop_data;
            rsp.op    <= pop_data.op;
            rsp.rdata <= '0;
            rsp.error <= pop_data.misaligned;
        end else if (state == WRITE && bvalid) begin
            rsp.error <= (bresp != RESP_OKAY);
        end else if (state == READ && rvalid) begin
            rsp.error <= (rresp != RESP_OKAY);
            rsp.rdata <= (rresp != RESP_OKAY) ? '0 : load_ext;
        end
    end

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int RAM_AW = 10
) (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         awvalid,
    output logic              awready,
    input  wire logic [31:0]  awaddr,
    input  wire logic         wvalid,
    output logic              wready,
    input  wire logic [63:0]  wdata,
    input  wire logic [7:0]   wstrb,
    output logic              bvalid,
    input  wire logic         bready,
    output logic [1:0]        bresp,
    input  wire logic         arvalid,
    output logic              arready,
    input  wire logic [31:0]  araddr,
    output logic              rvalid,
    input  wire logic         rready,
    output logic [63:0]       rdata,
    output logic [1:0]        rresp
);
    import mem_pkg::*;

    logic [63:0] mem [2**RAM_AW];

    logic        aw_got;
    logic        w_got;
    logic [31:0] aw_addr_q;
    logic [63:0] w_data_q;
    logic [7:0]  w_strb_q;
    logic        aw_have;
    logic        w_have;
    logic        wr_go;
    logic [31:0] wr_addr;
    logic [63:0] wr_data;
    logic [7:0]  wr_strb;
    logic [31:0] wr_off;
    logic [31:0] rd_off;
    logic        wr_in_range;
    logic        rd_in_range;

    // both ready together while no response is pending
    assign awready = !aw_got && !bvalid;
    assign wready  = !w_got && !bvalid;
    assign arready = !rvalid;

    assign aw_have = aw_got || (awvalid && awready);
    assign w_have  = w_got || (wvalid && wready);
    assign wr_go   = aw_have && w_have && !bvalid;

    // take the held copy if that half arrived earlier
    assign wr_addr = aw_got ? aw_addr_q : awaddr;
    assign wr_data = w_got ? w_data_q : wdata;
    assign wr_strb = w_got ? w_strb_q : wstrb;

    // below base wraps to a large offset and fails the same check
    assign wr_off      = wr_addr - RAM_BASE;
    assign rd_off      = araddr - RAM_BASE;
    assign wr_in_range = (wr_off[31:RAM_AW+3] == '0);
    assign rd_in_range = (rd_off[31:RAM_AW+3] == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_go) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
            end else begin
                aw_got <= aw_have;
                w_got  <= w_have;
                if (bvalid && bready) begin
                    bvalid <= 1'b0;
                end
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            aw_addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (wr_go) begin
            bresp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        end
        if (arvalid && arready) begin
            rresp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
            rdata <= rd_in_range ? mem[rd_off[RAM_AW+2:3]] : '0;
        end
    end

    // byte enables, out of window leaves memory alone
    always_ff @(posedge clk) begin
        if (wr_go && wr_in_range) begin
            for (int i = 0; i < 8; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_off[RAM_AW+2:3]][i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/lsu_issue.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_issue (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               cmd_valid,
    output logic                    cmd_ready,
    input  wire mem_pkg::mem_cmd_t  cmd,
    output logic                    push,
    output mem_pkg::mem_req_t       push_data,
    input  wire logic               full
);
    import mem_pkg::*;

    logic     started;
    logic     held;
    mem_req_t req_nxt;
    logic     misaligned;
    logic [7:0] size_mask;

    // alignment and byte mask per access size
    always_comb begin
        misaligned = 1'b0;
        size_mask  = 8'h01;
        case (cmd.width)
            WDT8: begin
                misaligned = 1'b0;
                size_mask  = 8'h01;
            end
            WDT16: begin
                misaligned = cmd.addr[0];
                size_mask  = 8'h03;
            end
            WDT32: begin
                misaligned = |cmd.addr[1:0];
                size_mask  = 8'h0f;
            end
            WDT64: begin
                misaligned = |cmd.addr[2:0];
                size_mask  = 8'hff;
            end
        endcase
    end

    always_comb begin
        req_nxt.op          = cmd.op;
        req_nxt.width       = cmd.width;
        req_nxt.is_unsigned = cmd.is_unsigned;
        req_nxt.addr        = cmd.addr;
        req_nxt.wstrb       = size_mask << cmd.addr[2:0];
        // move store value up into its lane
        req_nxt.wdata       = cmd.wdata << {cmd.addr[2:0], 3'b000};
        req_nxt.misaligned  = misaligned;
    end

    // skid register drains as soon as the fifo has room
    assign push      = held && !full;
    assign cmd_ready = started && (!held || !full);

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
            held    <= 1'b0;
        end else begin
            started <= 1'b1;
            if (cmd_valid && cmd_ready) begin
                held <= 1'b1;
            end else if (push) begin
                held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            push_data <= req_nxt;
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // access size, matches funct3[1:0] of RV64 loads and stores
    typedef enum logic [1:0] {
        WDT8  = 2'b00,
        WDT16 = 2'b01,
        WDT32 = 2'b10,
        WDT64 = 2'b11
    } width_e;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    // command as it arrives from the core side
    typedef struct packed {
        mem_op_e     op;
        width_e      width;
        logic        is_unsigned;
        logic [31:0] addr;
        logic [63:0] wdata;
    } mem_cmd_t;

    // wdata already sits in its byte lanes here
    typedef struct packed {
        mem_op_e     op;
        width_e      width;
        logic        is_unsigned;
        logic [31:0] addr;
        logic [7:0]  wstrb;
        logic [63:0] wdata;
        logic        misaligned;
    } mem_req_t;

    typedef struct packed {
        mem_op_e     op;
        logic [63:0] rdata;
        logic        error;
    } mem_rsp_t;

    // first ram doubleword
    localparam logic [31:0] RAM_BASE = 32'h8000_0000;

    // axi response codes in use
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- logic/mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys #(
    parameter int FIFO_DEPTH = 4,
    parameter int RAM_AW     = 10
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               cmd_valid,
    output logic                    cmd_ready,
    input  wire mem_pkg::mem_cmd_t  cmd,
    output logic                    rsp_valid,
    input  wire logic               rsp_ready,
    output mem_pkg::mem_rsp_t       rsp
);
    import mem_pkg::*;

    logic        push;
    mem_req_t    push_data;
    logic        full;
    logic        pop;
    mem_req_t    pop_data;
    logic        empty;

    // axi4-lite between master and ram
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [63:0] rdata;
    logic [1:0]  rresp;

    lsu_issue lsu_issue_i (
        .clk, .rst, .cmd_valid, .cmd_ready, .cmd, .push, .push_data, .full
    );

    req_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) req_fifo_i (
        .clk, .rst, .push, .push_data, .full, .pop, .pop_data, .empty
    );

    axil_master axil_master_i (
        .clk, .rst, .empty, .pop, .pop_data,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp, .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata, .rresp,
        .rsp_valid, .rsp_ready, .rsp
    );

    data_ram #(
        .RAM_AW(RAM_AW)
    ) data_ram_i (
        .clk, .rst,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp, .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata, .rresp
    );

endmodule

`default_nettype wire

//--- logic/req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               push,
    input  wire mem_pkg::mem_req_t  push_data,
    output logic                    full,
    input  wire logic               pop,
    output mem_pkg::mem_req_t       pop_data,
    output logic                    empty
);
    import mem_pkg::*;

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    mem_req_t        mem [FIFO_DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_push;
    logic            do_pop;

    assign full     = (count == CW'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // wrap by compare, depth need not be a power of two
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

//--- sim/mem_subsys_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_asserts (
    input wire logic              clk,
    input wire logic              rst,
    input wire logic              rsp_valid,
    input wire logic              rsp_ready,
    input wire mem_pkg::mem_rsp_t rsp,
    input wire logic              awvalid,
    input wire logic              awready,
    input wire logic              arvalid,
    input wire logic              arready,
    input wire logic              rvalid,
    input wire logic              bvalid,
    input wire logic [1:0]        state
);
    // encoding of IDLE in the master FSM
    localparam logic [1:0] IDLE_CODE = 2'd0;

    int fail_count = 0;

    rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
        $error("response changed or dropped while stalled");
        fail_count++;
    end

    // valid holds until ready, then drops since only one address goes out
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid |=> (awvalid == !$past(awready)))
    else begin
        $error("awvalid dropped before awready or stayed up after it");
        fail_count++;
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid |=> (arvalid == !$past(arready)))
    else begin
        $error("arvalid dropped before arready or stayed up after it");
        fail_count++;
    end

    no_resp_in_idle: assert property (@(posedge clk) disable iff (rst)
        state == IDLE_CODE |-> !rvalid && !bvalid)
    else begin
        $error("bus response seen while the master is idle");
        fail_count++;
    end

endmodule

bind axil_master mem_subsys_asserts handshake_asserts_i (
    .clk, .rst, .rsp_valid, .rsp_ready, .rsp,
    .awvalid, .awready, .arvalid, .arready, .rvalid, .bvalid,
    .state(state)
);

`default_nettype wire

//--- sim/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;
    import mem_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int RAM_AW     = 10;
    localparam int TIMEOUT    = 200;

    // scratch areas inside the ram window
    localparam logic [31:0] WIDTH_BASE  = RAM_BASE + 32'h40;
    localparam logic [31:0] MERGE_BASE  = RAM_BASE + 32'h80;
    localparam logic [31:0] STREAM_BASE = RAM_BASE + 32'h200;

    logic     clk;
    logic     rst;
    logic     cmd_valid;
    logic     cmd_ready;
    mem_cmd_t cmd;
    logic     rsp_valid;
    logic     rsp_ready;
    mem_rsp_t rsp;

    logic [63:0] ref_mem [2**RAM_AW];
    integer      seed = 52;
    mem_cmd_t    cmd_q[$];
    mem_rsp_t    exp_q[$];

    tb_clock clock_i (
        .clk
    );

    mem_subsys #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .RAM_AW(RAM_AW)
    ) mem_subsys_i (
        .clk, .rst, .cmd_valid, .cmd_ready, .cmd, .rsp_valid, .rsp_ready, .rsp
    );

    task automatic stop_with_fail();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rsp(input string name, input mem_rsp_t exp, input mem_rsp_t act);
        if (act !== exp) begin
            $display("Fail %s: expected op=%0d rdata=%h error=%b, actual op=%0d rdata=%h error=%b",
                     name, exp.op, exp.rdata, exp.error, act.op, act.rdata, act.error);
            stop_with_fail();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            stop_with_fail();
        end
    endtask

    function automatic mem_cmd_t make_cmd(input mem_op_e op, input width_e w, input logic u,
                                          input logic [31:0] a, input logic [63:0] d);
        mem_cmd_t c;
        c.op          = op;
        c.width       = w;
        c.is_unsigned = u;
        c.addr        = a;
        c.wdata       = d;
        return c;
    endfunction

    // reference model, also updates ref_mem on a good store
    function automatic mem_rsp_t predict(input mem_cmd_t c);
        int                nbytes;
        int                lane;
        logic [63:0]       mask;
        logic [63:0]       fld;
        logic [RAM_AW-1:0] idx;
        logic              in_win;
        mem_rsp_t          r;
        nbytes  = 1 << int'(c.width);
        lane    = int'(c.addr[2:0]);
        mask    = (nbytes == 8) ? '1 : (64'd1 << (nbytes * 8)) - 64'd1;
        in_win  = (c.addr >= RAM_BASE) && ((c.addr - RAM_BASE) < (32'd8 << RAM_AW));
        r.op    = c.op;
        r.rdata = '0;
        r.error = 1'b0;
        if ((lane % nbytes) != 0 || !in_win) begin
            r.error = 1'b1;
            return r;
        end
        idx = RAM_AW'((c.addr - RAM_BASE) >> 3);
        if (c.op == OP_STORE) begin
            ref_mem[idx] = (ref_mem[idx] & ~(mask << (lane * 8)))
                         | ((c.wdata & mask) << (lane * 8));
        end else begin
            fld = (ref_mem[idx] >> (lane * 8)) & mask;
            // top bit of the field decides the fill
            if (!c.is_unsigned && (fld & (mask & ~(mask >> 1))) != '0) begin
                fld = fld | ~mask;
            end
            r.rdata = fld;
        end
        return r;
    endfunction

    // called on a rising edge, returns on the handshake edge
    task automatic send_cmd(input mem_cmd_t c);
        int t;
        t = 0;
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(negedge clk);
        while (!cmd_ready) begin
            t++;
            if (t > TIMEOUT) begin
                $display("timeout: cmd_ready stayed low");
                stop_with_fail();
            end
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic wait_rsp(output mem_rsp_t r);
        int t;
        t = 0;
        @(negedge clk);
        while (!(rsp_valid && rsp_ready)) begin
            t++;
            if (t > TIMEOUT) begin
                $display("timeout: no response came back");
                stop_with_fail();
            end
            @(negedge clk);
        end
        r = rsp;
        @(posedge clk);
    endtask

    task automatic do_access(input string name, input mem_cmd_t c);
        mem_rsp_t exp;
        mem_rsp_t act;
        exp = predict(c);
        @(posedge clk);
        send_cmd(c);
        cmd_valid <= 1'b0;
        wait_rsp(act);
        check_rsp(name, exp, act);
    endtask

    task automatic test_reset();
        int t;
        // rst is high from time zero, released on the fifth edge
        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            check_flag("reset rsp_valid", 1'b0, rsp_valid);
            check_flag("reset cmd_ready", 1'b0, cmd_ready);
        end
        @(posedge clk);
        rst       <= 1'b0;
        rsp_ready <= 1'b1;
        @(negedge clk);
        // first cycle out of reset, ready comes one cycle later
        check_flag("release rsp_valid", 1'b0, rsp_valid);
        check_flag("release cmd_ready", 1'b0, cmd_ready);
        t = 0;
        while (!cmd_ready) begin
            t++;
            if (t > TIMEOUT) begin
                $display("timeout: cmd_ready never rose after reset");
                stop_with_fail();
            end
            @(negedge clk);
        end
    endtask

    task automatic test_width_round_trip();
        int          nbytes;
        logic [63:0] data;
        logic [31:0] addr;
        for (int w = 0; w < 4; w++) begin
            for (int u = 0; u < 2; u++) begin
                nbytes = 1 << w;
                for (int lane = 0; lane < 8; lane += nbytes) begin
                    data = {$random(seed), $random(seed)};
                    // force a negative field on every other lane
                    if (((lane / nbytes) % 2) == 0) begin
                        data = data | (64'd1 << (nbytes * 8 - 1));
                    end
                    addr = WIDTH_BASE + 32'(lane);
                    do_access($sformatf("width w%0d u%0d lane%0d store", w, u, lane),
                              make_cmd(OP_STORE, width_e'(w[1:0]), u[0], addr, data));
                    do_access($sformatf("width w%0d u%0d lane%0d load", w, u, lane),
                              make_cmd(OP_LOAD, width_e'(w[1:0]), u[0], addr, '0));
                end
            end
        end
    endtask

    task automatic test_byte_merge();
        for (int i = 0; i < 8; i++) begin
            do_access("merge byte store",
                      make_cmd(OP_STORE, WDT8, 1'b0, MERGE_BASE + 32'(i), 64'(17 * (i + 1))));
        end
        do_access("merge half store",
                  make_cmd(OP_STORE, WDT16, 1'b0, MERGE_BASE + 32'd2, 64'hbeef));
        do_access("merge word store",
                  make_cmd(OP_STORE, WDT32, 1'b0, MERGE_BASE + 32'd4, 64'hcafe_f00d));
        do_access("merge double load", make_cmd(OP_LOAD, WDT64, 1'b0, MERGE_BASE, '0));
        do_access("merge signed byte load",
                  make_cmd(OP_LOAD, WDT8, 1'b0, MERGE_BASE + 32'd7, '0));
    endtask

    task automatic test_misaligned();
        do_access("misaligned half load", make_cmd(OP_LOAD, WDT16, 1'b0, MERGE_BASE + 32'd1, '0));
        do_access("misaligned half store",
                  make_cmd(OP_STORE, WDT16, 1'b0, MERGE_BASE + 32'd3, 64'hffff));
        do_access("misaligned word load", make_cmd(OP_LOAD, WDT32, 1'b1, MERGE_BASE + 32'd2, '0));
        do_access("misaligned word store",
                  make_cmd(OP_STORE, WDT32, 1'b0, MERGE_BASE + 32'd6, 64'h1234_5678));
        do_access("misaligned double store",
                  make_cmd(OP_STORE, WDT64, 1'b0, MERGE_BASE + 32'd4, '1));
        do_access("misaligned double load", make_cmd(OP_LOAD, WDT64, 1'b0, MERGE_BASE + 32'd4, '0));
        do_access("misaligned unchanged", make_cmd(OP_LOAD, WDT64, 1'b0, MERGE_BASE, '0));
    endtask

    task automatic test_window();
        logic [31:0] below;
        logic [31:0] above;
        logic [31:0] first_dw;
        logic [31:0] last_dw;
        below    = RAM_BASE - 32'd8;
        above    = RAM_BASE + (32'd8 << RAM_AW);
        first_dw = RAM_BASE;
        last_dw  = above - 32'd8;
        // a wrapped index would land on the first or last doubleword
        do_access("window first fill",
                  make_cmd(OP_STORE, WDT64, 1'b0, first_dw, 64'h0123_4567_89ab_cdef));
        do_access("window last fill",
                  make_cmd(OP_STORE, WDT64, 1'b0, last_dw, 64'hfedc_ba98_7654_3210));
        do_access("window below store", make_cmd(OP_STORE, WDT64, 1'b0, below, 64'h5a5a));
        do_access("window below load", make_cmd(OP_LOAD, WDT64, 1'b0, below, '0));
        do_access("window above store", make_cmd(OP_STORE, WDT32, 1'b0, above, 64'h77));
        do_access("window above load", make_cmd(OP_LOAD, WDT32, 1'b0, above + 32'd4, '0));
        do_access("window zero load", make_cmd(OP_LOAD, WDT8, 1'b1, 32'h0, '0));
        do_access("window first unchanged", make_cmd(OP_LOAD, WDT64, 1'b0, first_dw, '0));
        do_access("window last unchanged", make_cmd(OP_LOAD, WDT64, 1'b0, last_dw, '0));
    endtask

    task automatic issue_all();
        @(posedge clk);
        foreach (cmd_q[i]) begin
            send_cmd(cmd_q[i]);
        end
        cmd_valid <= 1'b0;
    endtask

    // toggles rsp_ready at random and checks each response in order
    task automatic collect_all();
        mem_rsp_t    act;
        logic [31:0] rnd;
        int          t;
        for (int n = 0; n < cmd_q.size(); n++) begin
            t = 0;
            do begin
                @(posedge clk);
                rnd = $random(seed);
                rsp_ready <= rnd[0];
                @(negedge clk);
                t++;
                if (t > TIMEOUT) begin
                    $display("timeout: stream response %0d never arrived", n);
                    stop_with_fail();
                end
            end while (!(rsp_valid && rsp_ready));
            act = rsp;
            check_rsp($sformatf("stream %0d", n), exp_q[n], act);
        end
    endtask

    task automatic test_stream();
        logic [31:0] r;
        int          nbytes;
        int          lane;
        int          dw;
        mem_cmd_t    c;
        for (int i = 0; i < 8; i++) begin
            do_access("stream fill", make_cmd(OP_STORE, WDT64, 1'b0, STREAM_BASE + 32'(i * 8),
                                              {$random(seed), $random(seed)}));
        end
        for (int i = 0; i < 40; i++) begin
            r      = $random(seed);
            nbytes = 1 << int'(r[2:1]);
            lane   = int'(r[6:4]) & ~(nbytes - 1);
            dw     = int'(r[9:7]);
            c = make_cmd(r[0] ? OP_STORE : OP_LOAD, width_e'(r[2:1]), r[3],
                         STREAM_BASE + 32'(dw * 8 + lane), {$random(seed), $random(seed)});
            cmd_q.push_back(c);
            exp_q.push_back(predict(c));
        end
        fork
            issue_all();
            collect_all();
        join
        @(posedge clk);
        rsp_ready <= 1'b1;
    endtask

    initial begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        rsp_ready = 1'b0;
        foreach (ref_mem[i]) begin
            ref_mem[i] = '0;
        end
        test_reset();
        test_width_round_trip();
        test_byte_merge();
        test_misaligned();
        test_window();
        test_stream();
        @(posedge clk);
        if (mem_subsys_i.axil_master_i.handshake_asserts_i.fail_count != 0) begin
            $display("concurrent assertions failed in axil_master");
            stop_with_fail();
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);
    // half of the 100 ns period
    localparam int HALF_NS = 50;

    initial begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/mem_pkg.sv
logic/lsu_issue.sv
logic/req_fifo.sv
logic/axil_master.sv
logic/data_ram.sv
logic/mem_subsys.sv
sim/tb_clock.sv
sim/mem_subsys_asserts.sv
sim/mem_subsys_tb.sv
